/* compile.f */
+incdir+include
design/ecc_pkg.sv
design/ecc_regs.sv
design/ecc_encoder.sv
design/ecc_syndrome.sv
design/ecc_correct.sv
design/ecc_decoder.sv
design/ecc_top.sv
verif/ecc_checker.sv
verif/ecc_tb.sv

/* Makefile */
TOP := ecc_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

obj_dir/V$(TOP): compile.f $(wildcard design/*.sv verif/*.sv include/*.svh)
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f compile.f --top-module ecc_top

clean:
	rm -rf obj_dir $(LOG)

/* verif/ecc_tb.sv */
`include "ecc_params.svh"

module ecc_tb;

    localparam int TIMEOUT = 40; // Cycles allowed for a done wait

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   wr_en;
    logic                   rd_en;
    logic [`ECC_ADDR_W-1:0] addr;
    logic [`ECC_WORD-1:0]   wdata;
    logic [`ECC_WORD-1:0]   rdata;
    logic                   busy;
    logic                   done;
    logic [31:0]            lcg_state;
    ecc_pkg::ecc_result_t   expected;
    logic [31:0]            info;
    logic [31:0]            cw;
    logic [31:0]            mask;

    always #4 clk = ~clk;

    ecc_top dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (wr_en),
        .rd_en (rd_en),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .busy  (busy),
        .done  (done)
    );

    ecc_checker chk_i (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (wr_en),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .busy  (busy),
        .done  (done)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 16) % 32'(n)); // Upper bits mix better
    endfunction

    function automatic int par_of(input logic [1:0] mode);
        case (mode)
            2'd1:    return 5;
            2'd2:    return 6;
            default: return 4;
        endcase
    endfunction

    function automatic int info_of(input logic [1:0] mode);
        case (mode)
            2'd1:    return 11;
            2'd2:    return 26;
            default: return 4;
        endcase
    endfunction

    function automatic int len_of(input logic [1:0] mode);
        return par_of(mode) + info_of(mode);
    endfunction

    // j-th integer from 3 upward that is not a power of two
    function automatic int column_of(input int j);
        int c;
        int k;
        c = 2;
        k = -1;
        while (k < j) begin
            c++;
            if ((c & (c - 1)) != 0) k++;
        end
        return c;
    endfunction

    function automatic logic [31:0] model_encode(input logic [31:0] data, input logic [1:0] mode);
        logic [31:0] word;
        int          r;
        int          k;
        int          col;
        logic        p;
        r    = par_of(mode);
        k    = info_of(mode);
        word = '0;
        p    = 1'b0;
        for (int j = 0; j < k; j++) begin
            if (data[j]) begin
                word[r + j] = 1'b1;
                col         = column_of(j);
                for (int i = 0; i < r - 1; i++) begin
                    if (col[i]) word[i] = ~word[i];
                end
            end
        end
        for (int b = 0; b < r + k; b++) begin
            if (b != r - 1) p = p ^ word[b];
        end
        word[r - 1] = p; // Overall parity
        return word;
    endfunction

    function automatic ecc_pkg::ecc_result_t model_decode(input logic [31:0] rx_in,
                                                          input logic [1:0]  mode);
        ecc_pkg::ecc_result_t res;
        logic [31:0]          rx;
        int                   r;
        int                   k;
        int                   syn;
        int                   pos;
        logic                 ov;
        r   = par_of(mode);
        k   = info_of(mode);
        rx  = rx_in;
        syn = 0;
        ov  = 1'b0;
        for (int b = 0; b < r + k; b++) ov = ov ^ rx[b];
        // Syndrome as XOR of the columns of all set bits
        for (int i = 0; i < r - 1; i++) begin
            if (rx[i]) syn = syn ^ (1 << i);
        end
        for (int j = 0; j < k; j++) begin
            if (rx[r + j]) syn = syn ^ column_of(j);
        end
        res.num_of_errors = 2'd0;
        if (ov) begin
            res.num_of_errors = 2'd1;
            pos = r - 1;
            for (int i = 0; i < r - 1; i++) begin
                if (syn == (1 << i)) pos = i;
            end
            for (int j = 0; j < k; j++) begin
                if (syn == column_of(j)) pos = r + j;
            end
            rx[pos] = ~rx[pos];
        end else if (syn != 0) begin
            res.num_of_errors = 2'd2; // Passes uncorrected
        end
        res.data_out = (rx >> r) & ((32'(1) << k) - 32'd1);
        return res;
    endfunction

    // Distinct random bit positions below len
    function automatic logic [31:0] noise_mask(input int weight, input int len);
        logic [31:0] m;
        int          n;
        int          p;
        m = '0;
        n = 0;
        while (n < weight) begin
            p = rand_below(len);
            if (!m[p]) begin
                m[p] = 1'b1;
                n++;
            end
        end
        return m;
    endfunction

    task automatic write_reg(input logic [`ECC_ADDR_W-1:0] a, input logic [31:0] d);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic read_check(input logic [`ECC_ADDR_W-1:0] a, input string name,
                              input logic [31:0] value);
        rd_en = 1'b1;
        addr  = a;
        @(negedge clk);
        rd_en = 1'b0;
        chk_i.check_rdata(name, value);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while ((done !== 1'b1) && (n < TIMEOUT)) begin
            @(negedge clk);
            n++;
        end
        if (done !== 1'b1) chk_i.report_timeout("done after a CTRL write");
    endtask

    task automatic run_op(input logic [1:0] op, input logic [1:0] mode,
                          input logic [31:0] data, input logic [31:0] noise);
        write_reg(`ECC_ADDR_DATA_IN, data);
        write_reg(`ECC_ADDR_MODE, {30'b0, mode});
        write_reg(`ECC_ADDR_NOISE, noise);
        write_reg(`ECC_ADDR_CTRL, {30'b0, op});
        wait_done();
    endtask

    task automatic check_result(input ecc_pkg::ecc_result_t res);
        read_check(`ECC_ADDR_DATA_OUT, "rdata DATA_OUT", res.data_out);
        read_check(`ECC_ADDR_STATUS, "rdata STATUS", {29'b0, 1'b0, res.num_of_errors});
    endtask

    initial begin
        rst_n     = 1'b0;
        wr_en     = 1'b0;
        rd_en     = 1'b0;
        addr      = '0;
        wdata     = '0;
        lcg_state = 32'hea24_9a1c;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        chk_i.check_idle();
        read_check(`ECC_ADDR_DATA_OUT, "rdata DATA_OUT", 32'h0);
        read_check(`ECC_ADDR_STATUS, "rdata STATUS", 32'h0);
        chk_i.end_test("reset");

        for (int m = 0; m < 4; m++) begin // Mode 3 acts as the 8 bit mode
            for (int n = 0; n < 5; n++) begin
                info = lcg_next();
                run_op(ecc_pkg::OP_ENCODE, 2'(m), info, lcg_next());
                expected.data_out      = model_encode(info, 2'(m));
                expected.num_of_errors = 2'd0;
                check_result(expected);
            end
        end
        chk_i.end_test("encode");

        for (int m = 0; m < 4; m++) begin
            for (int n = 0; n < 6; n++) begin
                cw = model_encode(lcg_next(), 2'(m));
                if (n % 2 == 1) cw = cw ^ (32'(1) << rand_below(len_of(2'(m))));
                run_op(ecc_pkg::OP_DECODE, 2'(m), cw, 32'h0);
                check_result(model_decode(cw, 2'(m)));
            end
        end
        chk_i.end_test("decode");

        for (int m = 0; m < 4; m++) begin
            for (int w = 0; w < 3; w++) begin
                for (int n = 0; n < 3; n++) begin
                    info = lcg_next();
                    mask = noise_mask(w, len_of(2'(m)));
                    run_op(ecc_pkg::OP_CHANNEL, 2'(m), info, mask);
                    check_result(model_decode(model_encode(info, 2'(m)) ^ mask, 2'(m)));
                end
            end
        end
        chk_i.end_test("channel");

        // Second CTRL write and a data write land while busy
        info = lcg_next();
        mask = noise_mask(1, 16);
        write_reg(`ECC_ADDR_DATA_IN, info);
        write_reg(`ECC_ADDR_MODE, 32'd1);
        write_reg(`ECC_ADDR_NOISE, mask);
        write_reg(`ECC_ADDR_CTRL, {30'b0, ecc_pkg::OP_CHANNEL});
        write_reg(`ECC_ADDR_CTRL, {30'b0, ecc_pkg::OP_ENCODE});
        write_reg(`ECC_ADDR_DATA_IN, ~info);
        wait_done();
        expected = model_decode(model_encode(info, 2'd1) ^ mask, 2'd1);
        check_result(expected);
        write_reg(`ECC_ADDR_CTRL, 32'h3); // Reserved opcode
        repeat (8) @(negedge clk);
        check_result(expected);
        chk_i.end_test("busy_and_reserved");

        chk_i.print_summary();
        if (chk_i.error_count() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verif/ecc_checker.sv */
`include "ecc_params.svh"

module ecc_checker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  logic [`ECC_ADDR_W-1:0]   addr,
    input  logic [`ECC_WORD-1:0]     wdata,
    input  logic [`ECC_WORD-1:0]     rdata,
    input  logic                     busy,
    input  logic                     done
);

    int         mon_errors   = 0; // Found by the bus monitor
    int         chk_errors   = 0; // Found by the called checks
    int         base_errors  = 0;
    int         tests_run    = 0;
    int         tests_failed = 0;
    logic       timing       = 1'b0;
    int         cnt          = 0;
    logic [1:0] run_op       = 2'b00;

    // Edges from the CTRL write to done
    function automatic int latency_of(input logic [1:0] op);
        case (op)
            ecc_pkg::OP_ENCODE: return 2;
            ecc_pkg::OP_DECODE: return 3;
            default:            return 4;
        endcase
    endfunction

    // Outputs read here hold the values from before this edge
    always @(posedge clk) begin
        if (!rst_n) begin
            timing <= 1'b0;
            cnt    <= 0;
        end else begin
            if (timing) begin
                if (done) begin
                    if (cnt != latency_of(run_op)) begin
                        $display("ERR done latency: got 0x%0h expected 0x%0h",
                                 cnt, latency_of(run_op));
                        mon_errors++;
                    end
                    if (busy) begin
                        $display("ERR busy: got 0x1 expected 0x0 while done is high");
                        mon_errors++;
                    end
                    timing <= 1'b0;
                end else begin
                    if (!busy) begin
                        $display("ERR busy: got 0x0 expected 0x1 during an operation");
                        mon_errors++;
                    end
                    cnt <= cnt + 1;
                end
            end else if (busy || done) begin
                $display("Busy or done went high with no operation running");
                mon_errors++;
            end
            // Only an idle CTRL write with a defined opcode starts an op
            if (wr_en && (addr == `ECC_ADDR_CTRL) && !busy && (wdata[1:0] != 2'b11)) begin
                timing <= 1'b1;
                cnt    <= 0;
                run_op <= wdata[1:0];
            end
        end
    end

    task automatic check_rdata(input string name, input logic [`ECC_WORD-1:0] expected);
        if (rdata !== expected) begin
            $display("ERR %s: got 0x%08h expected 0x%08h", name, rdata, expected);
            chk_errors++;
        end
    endtask

    task automatic check_idle();
        if (busy !== 1'b0) begin
            $display("ERR busy: got 0x%0h expected 0x0", busy);
            chk_errors++;
        end
        if (done !== 1'b0) begin
            $display("ERR done: got 0x%0h expected 0x0", done);
            chk_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        chk_errors++;
    endtask

    task automatic end_test(input string name);
        int now_errors;
        now_errors = mon_errors + chk_errors;
        tests_run++;
        if (now_errors == base_errors) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, now_errors - base_errors);
        end
        base_errors = now_errors;
    endtask

    task automatic print_summary();
        $display("Tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, mon_errors + chk_errors);
    endtask

    function automatic int error_count();
        return mon_errors + chk_errors;
    endfunction

endmodule

/* design/ecc_top.sv */
`include "ecc_params.svh"

module ecc_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  logic                    rd_en,
    input  logic [`ECC_ADDR_W-1:0]  addr,
    input  logic [`ECC_WORD-1:0]    wdata,
    output logic [`ECC_WORD-1:0]    rdata,
    output logic                    busy,
    output logic                    done
);

    ecc_pkg::ecc_req_t    req;
    ecc_pkg::ecc_result_t dec_result;
    logic [`ECC_WORD-1:0] codeword;
    logic [`ECC_WORD-1:0] dec_in;
    logic                 start;
    logic                 enc_done;
    logic                 dec_start;
    logic                 dec_done;
    logic                 inject;

    // Channel op feeds the fresh codeword plus noise to the decoder
    assign inject = (req.op == ecc_pkg::OP_CHANNEL);
    assign dec_in = inject ? codeword : req.data;

    always_comb begin
        case (req.op)
            ecc_pkg::OP_DECODE:  dec_start = start;
            ecc_pkg::OP_CHANNEL: dec_start = enc_done;
            default:             dec_start = 1'b0; // Encode only
        endcase
    end

    ecc_regs regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .req        (req),
        .start      (start),
        .enc_done   (enc_done),
        .codeword   (codeword),
        .dec_done   (dec_done),
        .dec_result (dec_result),
        .busy       (busy),
        .done       (done)
    );

    ecc_encoder encoder_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .start    (start),
        .codeword (codeword),
        .enc_done (enc_done)
    );

    ecc_decoder decoder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .mode       (req.mode),
        .received   (dec_in),
        .noise      (req.noise),
        .inject     (inject),
        .start      (dec_start),
        .dec_result (dec_result),
        .dec_done   (dec_done)
    );

endmodule

/* design/ecc_decoder.sv */
`include "ecc_params.svh"

module ecc_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  ecc_pkg::work_mode_e    mode,
    input  logic [`ECC_WORD-1:0]   received,
    input  logic [`ECC_WORD-1:0]   noise,
    input  logic                   inject,
    input  logic                   start,
    output ecc_pkg::ecc_result_t   dec_result,
    output logic                   dec_done
);

    logic [`ECC_MAX_PAR-1:0] syndrome;
    logic [`ECC_WORD-1:0]    word;
    logic                    syn_valid;
    logic [`ECC_WORD-1:0]    corrected;
    logic [1:0]              num_of_errors;

    ecc_syndrome syndrome_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .mode     (mode),
        .received (received),
        .noise    (noise),
        .inject   (inject),
        .start    (start),
        .syndrome (syndrome),
        .word     (word),
        .valid    (syn_valid)
    );

    ecc_correct correct_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .mode          (mode),
        .word          (word),
        .syndrome      (syndrome),
        .valid         (syn_valid),
        .corrected     (corrected),
        .num_of_errors (num_of_errors),
        .done          (dec_done)
    );

    // Strip parity from the registered correction output
    always_comb begin
        dec_result.num_of_errors = num_of_errors;
        case (mode)
            ecc_pkg::MODE_16: dec_result.data_out = {{(`ECC_WORD-`ECC_INFO_M2){1'b0}},
                corrected[`ECC_LEN_M2-1:`ECC_PAR_M2]};
            ecc_pkg::MODE_32: dec_result.data_out = {{(`ECC_WORD-`ECC_INFO_M3){1'b0}},
                corrected[`ECC_LEN_M3-1:`ECC_PAR_M3]};
            default:          dec_result.data_out = {{(`ECC_WORD-`ECC_INFO_M1){1'b0}},
                corrected[`ECC_LEN_M1-1:`ECC_PAR_M1]};
        endcase
    end

endmodule

/* design/ecc_correct.sv */
`include "ecc_params.svh"

module ecc_correct (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ecc_pkg::work_mode_e      mode,
    input  logic [`ECC_WORD-1:0]     word,
    input  logic [`ECC_MAX_PAR-1:0]  syndrome,
    input  logic                     valid,
    output logic [`ECC_WORD-1:0]     corrected,
    output logic [1:0]               num_of_errors,
    output logic                     done
);

    localparam int SW = `ECC_MAX_PAR - 1;
    localparam int PW = $clog2(`ECC_WORD);

    logic [SW-1:0]        hsyn;
    logic                 overall_bad;
    logic [1:0]           nerr_next;
    logic [PW-1:0]        pos;
    logic [`ECC_WORD-1:0] flip;
    int                   npar;
    int                   j;

    assign hsyn        = syndrome[SW-1:0];
    assign overall_bad = syndrome[SW];

    always_comb begin
        if (overall_bad)       nerr_next = 2'd1;
        else if (hsyn == '0)   nerr_next = 2'd0;
        else                   nerr_next = 2'd2; // Double error left as is
    end

    // Bit position whose column equals the syndrome
    always_comb begin
        case (mode)
            ecc_pkg::MODE_16: npar = `ECC_PAR_M2;
            ecc_pkg::MODE_32: npar = `ECC_PAR_M3;
            default:          npar = `ECC_PAR_M1;
        endcase
        pos = PW'(npar - 1); // Zero syndrome points at the overall parity bit
        j   = 0;
        for (int i = 0; i < SW; i++) begin
            if (hsyn == SW'(1 << i)) pos = PW'(i);
        end
        for (int col = 3; col < `ECC_LEN_M3; col++) begin
            if ((col & (col - 1)) != 0) begin
                if (hsyn == SW'(col)) pos = PW'(npar + j);
                j++;
            end
        end
    end

    assign flip = (nerr_next == 2'd1) ? (`ECC_WORD'(1) << pos) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done          <= 1'b0;
            num_of_errors <= 2'd0;
        end else begin
            done <= valid;
            if (valid) num_of_errors <= nerr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)     corrected <= '0;
        else if (valid) corrected <= word ^ flip;
    end

    a_nerr_range: assert property (@(posedge clk) disable iff (!rst_n)
        num_of_errors != 2'd3);

endmodule

/* design/ecc_syndrome.sv */
`include "ecc_params.svh"

module ecc_syndrome (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ecc_pkg::work_mode_e      mode,
    input  logic [`ECC_WORD-1:0]     received,
    input  logic [`ECC_WORD-1:0]     noise,
    input  logic                     inject,
    input  logic                     start,
    output logic [`ECC_MAX_PAR-1:0]  syndrome, // Top bit flags bad overall parity
    output logic [`ECC_WORD-1:0]     word,
    output logic                     valid
);

    logic [`ECC_WORD-1:0]    noisy;
    logic [`ECC_WORD-1:0]    masked;
    logic [`ECC_INFO_M3-1:0] info;
    logic [`ECC_MAX_PAR-2:0] rx_par;
    logic [`ECC_MAX_PAR-2:0] hpar;
    logic                    overall_bad;

    assign noisy = inject ? (received ^ noise) : received; // Channel noise

    always_comb begin
        case (mode)
            ecc_pkg::MODE_16: begin
                masked = {{(`ECC_WORD-`ECC_LEN_M2){1'b0}}, noisy[`ECC_LEN_M2-1:0]};
                info   = {{(`ECC_INFO_M3-`ECC_INFO_M2){1'b0}},
                          noisy[`ECC_LEN_M2-1:`ECC_PAR_M2]};
                rx_par = {{(`ECC_MAX_PAR-`ECC_PAR_M2){1'b0}}, noisy[`ECC_PAR_M2-2:0]};
            end
            ecc_pkg::MODE_32: begin
                masked = noisy;
                info   = noisy[`ECC_LEN_M3-1:`ECC_PAR_M3];
                rx_par = noisy[`ECC_PAR_M3-2:0];
            end
            default: begin
                masked = {{(`ECC_WORD-`ECC_LEN_M1){1'b0}}, noisy[`ECC_LEN_M1-1:0]};
                info   = {{(`ECC_INFO_M3-`ECC_INFO_M1){1'b0}},
                          noisy[`ECC_LEN_M1-1:`ECC_PAR_M1]};
                rx_par = {{(`ECC_MAX_PAR-`ECC_PAR_M1){1'b0}}, noisy[`ECC_PAR_M1-2:0]};
            end
        endcase
    end

    assign hpar        = ecc_pkg::hamming_parity(info, mode);
    assign overall_bad = ^masked; // Even parity over the whole codeword

    always_ff @(posedge clk) begin
        if (!rst_n) valid <= 1'b0;
        else        valid <= start;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            syndrome <= '0;
            word     <= '0;
        end else if (start) begin
            syndrome <= {overall_bad, hpar ^ rx_par};
            word     <= masked;
        end
    end

endmodule

/* design/ecc_encoder.sv */
`include "ecc_params.svh"

module ecc_encoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ecc_pkg::ecc_req_t     req,
    input  logic                  start,
    output logic [`ECC_WORD-1:0]  codeword,
    output logic                  enc_done
);

    logic [`ECC_INFO_M3-1:0] info;
    logic [`ECC_MAX_PAR-2:0] hpar;
    logic [`ECC_WORD-1:0]    cw_next;
    logic [`ECC_WORD-1:0]    len_mask;

    always_comb begin
        case (req.mode)
            ecc_pkg::MODE_16: begin
                info     = {{(`ECC_INFO_M3-`ECC_INFO_M2){1'b0}}, req.data[`ECC_INFO_M2-1:0]};
                len_mask = {{(`ECC_WORD-`ECC_LEN_M2){1'b0}}, {`ECC_LEN_M2{1'b1}}};
            end
            ecc_pkg::MODE_32: begin
                info     = req.data[`ECC_INFO_M3-1:0];
                len_mask = '1;
            end
            default: begin // Unused mode value behaves as 8 bit
                info     = {{(`ECC_INFO_M3-`ECC_INFO_M1){1'b0}}, req.data[`ECC_INFO_M1-1:0]};
                len_mask = {{(`ECC_WORD-`ECC_LEN_M1){1'b0}}, {`ECC_LEN_M1{1'b1}}};
            end
        endcase
    end

    assign hpar = ecc_pkg::hamming_parity(info, req.mode);

    // Info above parity with overall parity on top of the Hamming bits
    always_comb begin
        case (req.mode)
            ecc_pkg::MODE_16: cw_next = {{(`ECC_WORD-`ECC_LEN_M2){1'b0}},
                info[`ECC_INFO_M2-1:0],
                ^{info[`ECC_INFO_M2-1:0], hpar[`ECC_PAR_M2-2:0]},
                hpar[`ECC_PAR_M2-2:0]};
            ecc_pkg::MODE_32: cw_next = {info, ^{info, hpar}, hpar};
            default:          cw_next = {{(`ECC_WORD-`ECC_LEN_M1){1'b0}},
                info[`ECC_INFO_M1-1:0],
                ^{info[`ECC_INFO_M1-1:0], hpar[`ECC_PAR_M1-2:0]},
                hpar[`ECC_PAR_M1-2:0]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) enc_done <= 1'b0;
        else        enc_done <= start;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)     codeword <= '0;
        else if (start) codeword <= cw_next;
    end

    // Padding above the mode length stays clear
    a_cw_padding: assert property (@(posedge clk) disable iff (!rst_n)
        enc_done |-> ((codeword & ~len_mask) == '0));

endmodule

/* design/ecc_regs.sv */
`include "ecc_params.svh"

module ecc_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  logic                     rd_en,
    input  logic [`ECC_ADDR_W-1:0]   addr,
    input  logic [`ECC_WORD-1:0]     wdata,
    output logic [`ECC_WORD-1:0]     rdata,
    output ecc_pkg::ecc_req_t        req,
    output logic                     start,
    input  logic                     enc_done,
    input  logic [`ECC_WORD-1:0]     codeword,
    input  logic                     dec_done,
    input  ecc_pkg::ecc_result_t     dec_result,
    output logic                     busy,
    output logic                     done
);

    logic [`ECC_WORD-1:0] data_reg;
    logic [`ECC_WORD-1:0] noise_reg;
    logic [`ECC_WORD-1:0] result_reg;
    logic [1:0]           mode_reg;
    logic [1:0]           nerr_reg;
    logic                 launch;
    logic                 finish;
    ecc_pkg::opcode_e     wr_op;

    assign wr_op  = ecc_pkg::opcode_e'(wdata[1:0]);
    // Reserved opcode and writes while busy are dropped
    assign launch = wr_en && (addr == `ECC_ADDR_CTRL) && !busy && (wdata[1:0] != 2'b11);

    // Completion strobe depends on the op that was launched
    assign finish = busy && ((req.op == ecc_pkg::OP_ENCODE) ? enc_done : dec_done);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_reg  <= '0;
            mode_reg  <= '0;
            noise_reg <= '0;
        end else if (wr_en) begin
            case (addr)
                `ECC_ADDR_DATA_IN: data_reg  <= wdata;
                `ECC_ADDR_MODE:    mode_reg  <= wdata[1:0];
                `ECC_ADDR_NOISE:   noise_reg <= wdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req   <= '0;
            start <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            start <= launch;
            done  <= finish;
            if (launch) begin
                req.op    <= wr_op;
                req.mode  <= ecc_pkg::work_mode_e'(mode_reg);
                req.data  <= data_reg;
                req.noise <= noise_reg;
                busy      <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_reg <= '0;
            nerr_reg   <= '0;
        end else if (finish) begin
            if (req.op == ecc_pkg::OP_ENCODE) begin
                result_reg <= codeword;
                nerr_reg   <= 2'd0;
            end else begin
                result_reg <= dec_result.data_out;
                nerr_reg   <= dec_result.num_of_errors;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (rd_en) begin
            case (addr)
                `ECC_ADDR_CTRL:     rdata <= {{(`ECC_WORD-2){1'b0}}, req.op};
                `ECC_ADDR_DATA_IN:  rdata <= data_reg;
                `ECC_ADDR_MODE:     rdata <= {{(`ECC_WORD-2){1'b0}}, mode_reg};
                `ECC_ADDR_NOISE:    rdata <= noise_reg;
                `ECC_ADDR_DATA_OUT: rdata <= result_reg;
                `ECC_ADDR_STATUS:   rdata <= {{(`ECC_WORD-3){1'b0}}, busy, nerr_reg};
                default:            rdata <= '0;
            endcase
        end
    end

    // One operation in flight at a time
    a_start_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(start) |-> !$past(busy));

endmodule

/* design/ecc_pkg.sv */
`include "ecc_params.svh"

package ecc_pkg;

    typedef enum logic [1:0] {
        MODE_8  = 2'b00,
        MODE_16 = 2'b01,
        MODE_32 = 2'b10
    } work_mode_e;

    typedef enum logic [1:0] {
        OP_ENCODE  = 2'b00,
        OP_DECODE  = 2'b01,
        OP_CHANNEL = 2'b10
    } opcode_e;

    typedef struct packed {
        opcode_e               op;
        work_mode_e            mode;
        logic [`ECC_WORD-1:0]  data;
        logic [`ECC_WORD-1:0]  noise;
    } ecc_req_t;

    typedef struct packed {
        logic [`ECC_WORD-1:0]  data_out;
        logic [1:0]            num_of_errors;
    } ecc_result_t;

    // Hamming parity bits of an info field, one bit per column bit
    function automatic logic [`ECC_MAX_PAR-2:0] hamming_parity(
        input logic [`ECC_INFO_M3-1:0] info,
        input work_mode_e              mode
    );
        logic [`ECC_MAX_PAR-2:0] par;
        int                      limit;
        int                      j;
        par = '0;
        j   = 0;
        case (mode)
            MODE_16: limit = `ECC_LEN_M2;
            MODE_32: limit = `ECC_LEN_M3;
            default: limit = `ECC_LEN_M1;
        endcase
        for (int col = 3; col < `ECC_LEN_M3; col++) begin
            if (((col & (col - 1)) != 0) && (col < limit)) begin // Skip power-of-two columns
                for (int b = 0; b < `ECC_MAX_PAR - 1; b++) begin
                    if (col[b]) par[b] = par[b] ^ info[j];
                end
                j++;
            end
        end
        return par;
    endfunction

endpackage

/* include/ecc_params.svh */
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

`define ECC_WORD    32
`define ECC_ADDR_W  5

// Codeword, info and parity lengths per mode
`define ECC_LEN_M1  8
`define ECC_LEN_M2  16
`define ECC_LEN_M3  32
`define ECC_INFO_M1 4
`define ECC_INFO_M2 11
`define ECC_INFO_M3 26
`define ECC_PAR_M1  4
`define ECC_PAR_M2  5
`define ECC_PAR_M3  6
`define ECC_MAX_PAR 6

// Register map
`define ECC_ADDR_CTRL     5'h00
`define ECC_ADDR_DATA_IN  5'h04
`define ECC_ADDR_MODE     5'h08
`define ECC_ADDR_NOISE    5'h0C
`define ECC_ADDR_DATA_OUT 5'h10
`define ECC_ADDR_STATUS   5'h14

`endif
